// ==== hdl/ahb_bridge_defs.svh ====
// bus widths, sram depth and wait-state count, included by every bridge file that sizes a signal
`ifndef AHB_BRIDGE_DEFS_SVH
`define AHB_BRIDGE_DEFS_SVH

// ahb-lite bus
`define AHB_ADDR_W 32
`define AHB_DATA_W 32
`define AHB_STRB_W 4        // one enable per byte lane

// on-chip sram slave
`define SRAM_WORDS 64       // word index taken from addr[7:2]
`define SRAM_IDX_W 6        // log2 of SRAM_WORDS

// cycles HREADY is held low at the start of each data phase
// 0 to 3 are all legal
`define SRAM_WAIT_STATES 1
`define SRAM_WAIT_W 2       // counter width, covers up to 3 waits

`endif

// ==== hdl/ahb_bridge_pkg.sv ====
// shared types for the generic-bus to ahb-lite bridge, imported by the rtl and the testbench

`include "ahb_bridge_defs.svh"

package ahb_bridge_pkg;

  // one data word, seen whole or as byte lanes
  typedef union packed {
    logic [`AHB_DATA_W-1:0]      word;
    logic [`AHB_STRB_W-1:0][7:0] lanes;  // lanes[0] is bits 7:0
  } bus_word_u;

  // HTRANS encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // HSIZE encodings, only up to a full word here
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

endpackage

// ==== hdl/ahb_master.sv ====
// ahb-lite master that turns one held generic-bus request into one NONSEQ transfer
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module ahb_master (
  input  logic                         CLK,
  input  logic                         nRST,
  // generic bus side
  input  logic                         ren,
  input  logic                         wen,
  input  logic [`AHB_ADDR_W-1:0]       addr,
  input  logic [`AHB_DATA_W-1:0]       wdata,
  input  logic [`AHB_STRB_W-1:0]       byte_en,
  output logic                         busy,
  output logic [`AHB_DATA_W-1:0]       rdata,
  // ahb-lite side
  output logic [`AHB_ADDR_W-1:0]       HADDR,
  output ahb_bridge_pkg::htrans_t      HTRANS,
  output logic                         HWRITE,
  output ahb_bridge_pkg::hsize_t       HSIZE,
  output logic [`AHB_DATA_W-1:0]       HWDATA,
  output logic [2:0]                   HBURST,
  output logic [3:0]                   HPROT,
  output logic                         HMASTLOCK,
  input  logic                         HREADY,
  input  logic [`AHB_DATA_W-1:0]       HRDATA
);

  import ahb_bridge_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_DATA
  } state_t;

  state_t state, n_state;

  logic                   req;       // either strobe up
  logic [1:0]             low_idx;   // lowest enabled lane
  logic [`AHB_DATA_W-1:0] wdata_q;   // write data held for the data phase

  assign req = ren | wen;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      state <= ST_IDLE;
    else
      state <= n_state;
  end

  // one transfer in flight, new address phase only from idle
  always_comb begin
    n_state = state;
    case (state)
      ST_IDLE: if (req) n_state = ST_DATA;
      ST_DATA: if (HREADY) n_state = ST_IDLE;  // stretched while slave waits
      default: n_state = ST_IDLE;
    endcase
  end

  // size straight from the enable pattern
  always_comb begin
    if (byte_en == 4'b1111)
      HSIZE = WORD;
    else if (byte_en == 4'b1100 || byte_en == 4'b0011)
      HSIZE = HALF;
    else
      HSIZE = BYTE;
  end

  // low address bits point at the first lane written or read
  always_comb begin
    casez (byte_en)
      4'b???1: low_idx = 2'd0;
      4'b??10: low_idx = 2'd1;
      4'b?100: low_idx = 2'd2;
      4'b1000: low_idx = 2'd3;
      default: low_idx = 2'd0;  // no lane enabled
    endcase
  end

  // address phase, combinational off the request while idle
  always_comb begin
    if (state == ST_IDLE && req) begin
      HTRANS = NONSEQ;
      HWRITE = wen & ~ren;  // read wins, as on the generic bus
      HADDR  = {addr[`AHB_ADDR_W-1:2], low_idx};
    end else begin
      HTRANS = IDLE;
      HWRITE = 1'b0;
      HADDR  = '0;
    end
  end

  // capture write data on the address-phase edge
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && req)
      wdata_q <= wdata;
  end

  assign HWDATA = wdata_q;

  // single transfers only, no lock, default protection
  assign HBURST    = 3'b000;
  assign HPROT     = 4'b0000;
  assign HMASTLOCK = 1'b0;

  // busy drops for the one cycle the data phase completes
  assign busy  = ~(HREADY & (state == ST_DATA));
  assign rdata = HRDATA;

endmodule

// ==== hdl/ahb_sram_slave.sv ====
// ahb-lite sram slave with fixed wait states and byte-lane write merge, one per bridge
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module ahb_sram_slave (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic [`AHB_ADDR_W-1:0]     HADDR,
  input  ahb_bridge_pkg::htrans_t    HTRANS,
  input  logic                       HWRITE,
  input  ahb_bridge_pkg::hsize_t     HSIZE,
  input  logic [`AHB_DATA_W-1:0]     HWDATA,
  output logic                       HREADY,
  output logic [`AHB_DATA_W-1:0]     HRDATA,
  output logic                       HRESP
);

  import ahb_bridge_pkg::*;

  // storage, cleared by reset
  bus_word_u mem [`SRAM_WORDS];

  // address phase capture
  logic                    dphase;    // data phase open
  logic [`SRAM_WAIT_W-1:0] wait_cnt;  // waits left before HREADY
  logic                    write_q;
  logic [`SRAM_IDX_W-1:0]  idx_q;     // word index, addr[7:2]
  logic [1:0]              low_q;     // byte offset in the word
  hsize_t                  size_q;

  logic                    sample;    // address phase accepted this edge
  logic                    done;      // final data-phase cycle
  logic [`AHB_STRB_W-1:0]  lane_mask;
  bus_word_u               old_word;
  bus_word_u               new_word;
  bus_word_u               merged;

  assign sample = (HTRANS == NONSEQ) && HREADY;
  assign done   = dphase && (wait_cnt == '0);

  // low while counting waits, high otherwise
  assign HREADY = ~dphase | (wait_cnt == '0);

  // data-phase control
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dphase   <= 1'b0;
      wait_cnt <= '0;
      write_q  <= 1'b0;
    end else if (sample) begin
      dphase   <= 1'b1;
      wait_cnt <= `SRAM_WAIT_W'(`SRAM_WAIT_STATES);
      write_q  <= HWRITE;
    end else if (dphase) begin
      if (wait_cnt != '0)
        wait_cnt <= wait_cnt - 1'b1;  // still stretching
      else
        dphase <= 1'b0;  // completes on this edge
    end
  end

  // address and size kept for the data phase
  always_ff @(posedge CLK) begin
    if (sample) begin
      idx_q  <= HADDR[`SRAM_IDX_W+1:2];  // higher bits alias
      low_q  <= HADDR[1:0];
      size_q <= HSIZE;
    end
  end

  // lanes touched by the registered transfer
  always_comb begin
    case (size_q)
      WORD:    lane_mask = 4'b1111;
      HALF:    lane_mask = low_q[1] ? 4'b1100 : 4'b0011;
      BYTE:    lane_mask = 4'b0001 << low_q;
      default: lane_mask = 4'b0000;
    endcase
  end

  // merge the enabled lanes over the stored word
  always_comb begin
    old_word      = mem[idx_q];
    new_word.word = HWDATA;
    merged        = old_word;
    for (int i = 0; i < `AHB_STRB_W; i++) begin
      if (lane_mask[i])
        merged.lanes[i] = new_word.lanes[i];
    end
  end

  // write lands on the closing edge of the data phase
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `SRAM_WORDS; i++)
        mem[i] <= '0;
    end else if (done && write_q) begin
      mem[idx_q] <= merged;
    end
  end

  // read word valid only in the completing cycle
  assign HRDATA = (done && !write_q) ? old_word.word : '0;

  // no error path, always OKAY
  assign HRESP = 1'b0;

endmodule

// ==== hdl/ahb_bridge_top.sv ====
// bridge top, generic bus in, ahb-lite master driving one sram slave inside
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module ahb_bridge_top (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   ren,
  input  logic                   wen,
  input  logic [`AHB_ADDR_W-1:0] addr,
  input  logic [`AHB_DATA_W-1:0] wdata,
  input  logic [`AHB_STRB_W-1:0] byte_en,
  output logic                   busy,
  output logic [`AHB_DATA_W-1:0] rdata
);

  import ahb_bridge_pkg::*;

  // ahb-lite wires between master and slave
  logic [`AHB_ADDR_W-1:0] haddr;
  htrans_t                htrans;
  logic                   hwrite;
  hsize_t                 hsize;
  logic [`AHB_DATA_W-1:0] hwdata;
  logic                   hready;
  logic [`AHB_DATA_W-1:0] hrdata;

  ahb_master ahb_master_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .ren       (ren),
    .wen       (wen),
    .addr      (addr),
    .wdata     (wdata),
    .byte_en   (byte_en),
    .busy      (busy),
    .rdata     (rdata),
    .HADDR     (haddr),
    .HTRANS    (htrans),
    .HWRITE    (hwrite),
    .HSIZE     (hsize),
    .HWDATA    (hwdata),
    .HBURST    (),        // fixed single, slave ignores it
    .HPROT     (),
    .HMASTLOCK (),
    .HREADY    (hready),
    .HRDATA    (hrdata)
  );

  ahb_sram_slave ahb_sram_slave_inst (
    .CLK    (CLK),
    .nRST   (nRST),
    .HADDR  (haddr),
    .HTRANS (htrans),
    .HWRITE (hwrite),
    .HSIZE  (hsize),
    .HWDATA (hwdata),
    .HREADY (hready),
    .HRDATA (hrdata),
    .HRESP  ()             // always OKAY, master has no error path
  );

endmodule

// ==== verif/ahb_bridge_sva.sv ====
// assertions on the master's ahb-lite outputs, bound into every ahb_master instance
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module ahb_bridge_sva (
  input logic                      CLK,
  input logic                      nRST,
  input logic                      ren,
  input logic                      wen,
  input logic                      busy,
  input logic                      in_data,  // master fsm in data state, ST_DATA is 1
  input ahb_bridge_pkg::htrans_t   HTRANS,
  input logic                      HREADY,
  input logic [`AHB_DATA_W-1:0]    HWDATA
);

  import ahb_bridge_pkg::*;

  int fail_count = 0;  // read by the testbench at the end of the run

  // single transfers only, so never BUSY or SEQ
  htrans_legal: assert property (@(posedge CLK) disable iff (!nRST)
    HTRANS == IDLE || HTRANS == NONSEQ)
    else begin
      fail_count++;
      $error("HTRANS shows a type other than IDLE or NONSEQ");
    end

  // address phase only from idle with a strobe up
  nonseq_from_idle: assert property (@(posedge CLK) disable iff (!nRST)
    HTRANS == NONSEQ |-> !in_data && (ren || wen))
    else begin
      fail_count++;
      $error("NONSEQ driven outside idle or without a request");
    end

  // write data held while the slave stretches
  hwdata_held: assert property (@(posedge CLK) disable iff (!nRST)
    in_data && !HREADY |=> $stable(HWDATA))
    else begin
      fail_count++;
      $error("HWDATA changed during a wait state");
    end

  // nothing completes right out of reset
  busy_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> busy)
    else begin
      fail_count++;
      $error("busy low in the first cycle after reset");
    end

endmodule

bind ahb_master ahb_bridge_sva ahb_bridge_sva_inst (
  .CLK     (CLK),
  .nRST    (nRST),
  .ren     (ren),
  .wen     (wen),
  .busy    (busy),
  .in_data (state),
  .HTRANS  (HTRANS),
  .HREADY  (HREADY),
  .HWDATA  (HWDATA)
);

// ==== verif/ahb_bridge_tb.sv ====
// random testbench for the bridge top, every completion checked against a byte-lane memory model
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module ahb_bridge_tb;

  import ahb_bridge_pkg::*;

  localparam int N_WORD  = 32;  // word write, word read back
  localparam int N_LANE  = 32;  // partial write, word read back
  localparam int N_B2B   = 64;  // mixed ops with no idle cycle
  localparam int N_ZERO  = 16;  // reads after the second reset
  localparam int N_ALIAS = 8;   // write, then read through an alias
  localparam int N_XFERS = 2 * N_WORD + 2 * N_LANE + N_B2B + N_ZERO + 2 * N_ALIAS;
  localparam int MAX_GAP = 2;   // idle cycles allowed between requests
  localparam int LATENCY = 1 + `SRAM_WAIT_STATES;
  localparam int TIMEOUT_CYCLES = N_XFERS * (2 + `SRAM_WAIT_STATES) + N_XFERS * MAX_GAP + 100;

  logic                   CLK;
  logic                   nRST;
  logic                   ren;
  logic                   wen;
  logic [`AHB_ADDR_W-1:0] addr;
  logic [`AHB_DATA_W-1:0] wdata;
  logic [`AHB_STRB_W-1:0] byte_en;
  logic                   busy;
  logic [`AHB_DATA_W-1:0] rdata;

  bus_word_u model [`SRAM_WORDS];  // expected sram contents
  integer    seed = 32'hfc00_7e75;
  int        error_count;
  int        check_count;

  ahb_bridge_top ahb_bridge_top_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .ren     (ren),
    .wen     (wen),
    .addr    (addr),
    .wdata   (wdata),
    .byte_en (byte_en),
    .busy    (busy),
    .rdata   (rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // hard stop if some request never completes
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge CLK);
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // legal enables only, full word, halves or one lane
  function automatic logic [3:0] rand_be();
    int pick;
    pick = $unsigned($random(seed)) % 7;
    case (pick)
      0:       return 4'b1111;
      1:       return 4'b0011;
      2:       return 4'b1100;
      3:       return 4'b0001;
      4:       return 4'b0010;
      5:       return 4'b0100;
      default: return 4'b1000;
    endcase
  endfunction

  function automatic int rand_gap();
    return $unsigned($random(seed)) % (MAX_GAP + 1);
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic apply_reset();
    ren  = 1'b0;
    wen  = 1'b0;
    nRST = 1'b0;
    for (int i = 0; i < `SRAM_WORDS; i++)
      model[i] = '0;  // sram clears on reset
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
  endtask

  // one generic-bus request, held until busy drops
  task automatic do_request(input string name, input logic write, input logic [31:0] a,
                            input logic [31:0] d, input logic [3:0] be, input int gap);
    int                     cycles;
    bus_word_u              nw;
    logic [`SRAM_IDX_W-1:0] idx;
    cycles  = 0;
    nw.word = d;
    idx     = a[`SRAM_IDX_W+1:2];  // upper address bits alias
    repeat (gap) begin
      ren = 1'b0;
      wen = 1'b0;
      @(posedge CLK);
      #1;
    end
    ren     = ~write;
    wen     = write;
    addr    = a;
    wdata   = d;
    byte_en = be;
    @(negedge CLK);
    while (busy) begin  // count busy cycles, watchdog guards a hang
      cycles++;
      @(negedge CLK);
    end
    check_value({name, " latency"}, LATENCY, cycles);
    if (write) begin
      for (int i = 0; i < `AHB_STRB_W; i++)
        if (be[i])
          model[idx].lanes[i] = nw.lanes[i];  // enabled lanes only
    end else begin
      check_value({name, " rdata"}, model[idx].word, rdata);
    end
    @(posedge CLK);
    #1;
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] r;
    int          sva_fails;
    error_count = 0;
    check_count = 0;
    ren     = 1'b0;
    wen     = 1'b0;
    addr    = '0;
    wdata   = '0;
    byte_en = '0;
    nRST    = 1'b0;
    apply_reset();
    // full words at random addresses
    for (int i = 0; i < N_WORD; i++) begin
      a = $random(seed);
      d = $random(seed);
      do_request("word_rw write", 1'b1, a, d, 4'b1111, rand_gap());
      do_request("word_rw read", 1'b0, a, 32'h0, 4'b1111, rand_gap());
    end
    // halfword and byte writes, word read back
    for (int i = 0; i < N_LANE; i++) begin
      a = $random(seed);
      d = $random(seed);
      do_request("lane_rw write", 1'b1, a, d, rand_be(), rand_gap());
      do_request("lane_rw read", 1'b0, a, 32'h0, 4'b1111, rand_gap());
    end
    // small word pool so reads hit recent writes
    for (int i = 0; i < N_B2B; i++) begin
      r = $random(seed);
      a = {r[31:8], 3'b000, r[4:2], 2'b00};
      d = $random(seed);
      do_request("b2b", r[5], a, d, rand_be(), 0);
    end
    apply_reset();  // second reset, memory back to zero
    for (int i = 0; i < N_ZERO; i++) begin
      a = $random(seed);
      do_request("after_reset read", 1'b0, a, 32'h0, 4'b1111, rand_gap());
    end
    // same word through different upper bits
    for (int i = 0; i < N_ALIAS; i++) begin
      a = $random(seed);
      r = $random(seed);
      d = $random(seed);
      do_request("alias write", 1'b1, a, d, 4'b1111, rand_gap());
      do_request("alias read", 1'b0, {r[31:8], a[7:0]}, 32'h0, 4'b1111, rand_gap());
    end
    ren = 1'b0;
    wen = 1'b0;
    repeat (4) @(posedge CLK);
    sva_fails = ahb_bridge_top_inst.ahb_master_inst.ahb_bridge_sva_inst.fail_count;
    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             check_count, error_count, sva_fails);
    if (error_count == 0 && sva_fails == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== ahb_bridge.f ====
+incdir+hdl
hdl/ahb_bridge_pkg.sv
hdl/ahb_master.sv
hdl/ahb_sram_slave.sv
hdl/ahb_bridge_top.sv
verif/ahb_bridge_sva.sv
verif/ahb_bridge_tb.sv

// ==== Makefile ====
# Verilator build and run of the ahb bridge testbench

TOP := ahb_bridge_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the verilator build directory"

test:
	verilator --binary --timing --assert -f ahb_bridge.f --top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir
